// File: csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// register numbers
`define CSR_CRMD         14'h000
`define CSR_PRMD         14'h001
`define CSR_ECFG         14'h004
`define CSR_ESTAT        14'h005
`define CSR_ERA          14'h006
`define CSR_EENTRY       14'h00c
`define CSR_SAVE0        14'h030
`define CSR_SAVE1        14'h031
`define CSR_SAVE2        14'h032
`define CSR_SAVE3        14'h033
`define CSR_TCFG         14'h041
`define CSR_TVAL         14'h042
`define CSR_TICLR        14'h044

// field ranges
`define CSR_CRMD_PLV     1:0
`define CSR_CRMD_IE      2
`define CSR_CRMD_DA      3
`define CSR_CRMD_PG      4
`define CSR_CRMD_DATF    6:5
`define CSR_CRMD_DATM    8:7
`define CSR_PRMD_PPLV    1:0
`define CSR_PRMD_PIE     2
`define CSR_ECFG_LIE     12:0
`define CSR_ESTAT_IS10   1:0
`define CSR_ESTAT_IS11   11
`define CSR_ESTAT_ECODE  21:16
`define CSR_ESTAT_ESUBCODE 30:22
`define CSR_EENTRY_VA    31:6
`define CSR_TCFG_EN      0
`define CSR_TCFG_PERIOD  1
`define CSR_TCFG_INITVAL 31:2
`define CSR_TICLR_CLR    0

// reset values
`define CRMD_RESET       32'h0000_0008
`define TIMER_STOPPED    32'hffff_ffff
`define ESTAT_TIMER_BIT  11

// exception codes
`define ECODE_INT        6'h00
`define ECODE_ADE        6'h08
`define ECODE_ALE        6'h09
`define ECODE_SYS        6'h0b
`define ECODE_BRK        6'h0c
`define ECODE_INE        6'h0d

`endif

// File: csr_pkg.sv
package csr_pkg;

    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;

    // software write port, one cycle strobe
    typedef struct packed {
        logic      we;
        csr_num_t  num;
        csr_data_t mask;
        csr_data_t val;
    } csr_write_t;

    // exception report from the pipeline
    typedef struct packed {
        logic      valid;
        ecode_t    ecode;
        esubcode_t esubcode;
        csr_data_t pc;
    } exc_event_t;

endpackage

// File: exc_csr_regs.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module exc_csr_regs
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t wr,
    input  exc_event_t exc,
    input  logic       ertn,
    input  logic       timer_pending,
    output csr_data_t  crmd,
    output csr_data_t  prmd,
    output csr_data_t  ecfg,
    output csr_data_t  estat,
    output csr_data_t  era,
    output csr_data_t  eentry,
    output logic       has_int,
    output csr_data_t  exc_entry,
    output csr_data_t  exc_retaddr
);

    plv_t        crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    plv_t        prmd_pplv;
    logic        prmd_pie;
    int_vec_t    ecfg_lie;
    logic [1:0]  estat_sw;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    csr_data_t   era_pc;
    logic [25:0] eentry_va;
    int_vec_t    estat_is;

    // masked merge against the current value, one per register
    csr_data_t crmd_wdata;
    csr_data_t prmd_wdata;
    csr_data_t ecfg_wdata;
    csr_data_t estat_wdata;
    csr_data_t era_wdata;
    csr_data_t eentry_wdata;

    assign crmd_wdata   = (wr.mask & wr.val) | (~wr.mask & crmd);
    assign prmd_wdata   = (wr.mask & wr.val) | (~wr.mask & prmd);
    assign ecfg_wdata   = (wr.mask & wr.val) | (~wr.mask & ecfg);
    assign estat_wdata  = (wr.mask & wr.val) | (~wr.mask & estat);
    assign era_wdata    = (wr.mask & wr.val) | (~wr.mask & era);
    assign eentry_wdata = (wr.mask & wr.val) | (~wr.mask & eentry);

    // exception beats ertn beats software write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (exc.valid) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.we && wr.num == `CSR_CRMD) begin
            crmd_plv <= crmd_wdata[`CSR_CRMD_PLV];
            crmd_ie  <= crmd_wdata[`CSR_CRMD_IE];
        end
    end

    // translation mode fields, software only
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (wr.we && wr.num == `CSR_CRMD) begin
            crmd_da   <= crmd_wdata[`CSR_CRMD_DA];
            crmd_pg   <= crmd_wdata[`CSR_CRMD_PG];
            crmd_datf <= crmd_wdata[`CSR_CRMD_DATF];
            crmd_datm <= crmd_wdata[`CSR_CRMD_DATM];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exc.valid) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr.we && wr.num == `CSR_PRMD) begin
            prmd_pplv <= prmd_wdata[`CSR_PRMD_PPLV];
            prmd_pie  <= prmd_wdata[`CSR_PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie <= '0;
            estat_sw <= '0;
        end else if (wr.we) begin
            if (wr.num == `CSR_ECFG) begin
                ecfg_lie <= ecfg_wdata[`CSR_ECFG_LIE];
            end
            if (wr.num == `CSR_ESTAT) begin
                estat_sw <= estat_wdata[`CSR_ESTAT_IS10];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era_pc         <= '0;
        end else if (exc.valid) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
            era_pc         <= exc.pc;
        end else if (wr.we && wr.num == `CSR_ERA) begin
            era_pc <= era_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            eentry_va <= '0;
        end else if (wr.we && wr.num == `CSR_EENTRY) begin
            eentry_va <= eentry_wdata[`CSR_EENTRY_VA];
        end
    end

    // only the timer and the two software lines exist
    assign estat_is = {1'b0, timer_pending, 9'b0, estat_sw};

    assign crmd   = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd   = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg   = {19'b0, ecfg_lie};
    assign estat  = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign era    = era_pc;
    assign eentry = {eentry_va, 6'b0};

    assign has_int     = crmd_ie & (|(estat_is & ecfg_lie));
    assign exc_entry   = eentry;
    assign exc_retaddr = era;

endmodule

// File: timer_cfg.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module timer_cfg
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t wr,
    output csr_data_t  tcfg
);

    logic        en;
    logic        period;
    logic [29:0] initval;
    csr_data_t   wdata;

    assign wdata = (wr.mask & wr.val) | (~wr.mask & tcfg);

    always_ff @(posedge clk) begin
        if (rst) begin
            en      <= 1'b0;
            period  <= 1'b0;
            initval <= '0;
        end else if (wr.we && wr.num == `CSR_TCFG) begin
            en      <= wdata[`CSR_TCFG_EN];
            period  <= wdata[`CSR_TCFG_PERIOD];
            initval <= wdata[`CSR_TCFG_INITVAL];
        end
    end

    assign tcfg = {initval, period, en};

endmodule

// File: csr_timer.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_timer
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t wr,
    input  csr_data_t  tcfg,
    output csr_data_t  tval,
    output logic       timer_pending
);

    csr_data_t tcfg_next;
    logic      tcfg_load;
    logic      ticlr_hit;

    // value tcfg takes at this edge if written now
    assign tcfg_next = (wr.mask & wr.val) | (~wr.mask & tcfg);
    assign tcfg_load = wr.we && wr.num == `CSR_TCFG && tcfg_next[`CSR_TCFG_EN];
    assign ticlr_hit = wr.we && wr.num == `CSR_TICLR &&
                       wr.mask[`CSR_TICLR_CLR] && wr.val[`CSR_TICLR_CLR];

    always_ff @(posedge clk) begin
        if (rst) begin
            tval <= `TIMER_STOPPED;
        end else if (tcfg_load) begin
            tval <= {tcfg_next[`CSR_TCFG_INITVAL], 2'b00};
        end else if (tcfg[`CSR_TCFG_EN] && tval != `TIMER_STOPPED) begin
            if (tval == '0 && tcfg[`CSR_TCFG_PERIOD]) begin
                tval <= {tcfg[`CSR_TCFG_INITVAL], 2'b00};
            end else begin
                // one-shot wraps to the stopped value
                tval <= tval - 32'd1;
            end
        end
    end

    // zero count wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_pending <= 1'b0;
        end else if (tval == '0) begin
            timer_pending <= 1'b1;
        end else if (ticlr_hit) begin
            timer_pending <= 1'b0;
        end
    end

endmodule

// File: csr_save_bank.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_save_bank
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t wr,
    output csr_data_t  save0,
    output csr_data_t  save1,
    output csr_data_t  save2,
    output csr_data_t  save3
);

    csr_data_t save_q [4];

    // SAVE0..SAVE3 are consecutive numbers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= '0;
            end
        end else if (wr.we) begin
            for (int i = 0; i < 4; i++) begin
                if (wr.num == csr_num_t'(`CSR_SAVE0 + i)) begin
                    save_q[i] <= (wr.mask & wr.val) | (~wr.mask & save_q[i]);
                end
            end
        end
    end

    assign save0 = save_q[0];
    assign save1 = save_q[1];
    assign save2 = save_q[2];
    assign save3 = save_q[3];

endmodule

// File: csr_read_select.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_read_select
    import csr_pkg::*;
(
    input  csr_num_t  rnum,
    input  csr_data_t crmd,
    input  csr_data_t prmd,
    input  csr_data_t ecfg,
    input  csr_data_t estat,
    input  csr_data_t era,
    input  csr_data_t eentry,
    input  csr_data_t save0,
    input  csr_data_t save1,
    input  csr_data_t save2,
    input  csr_data_t save3,
    input  csr_data_t tcfg,
    input  csr_data_t tval,
    output csr_data_t rval
);

    // TICLR and unimplemented numbers fall to the default
    always_comb begin
        case (rnum)
            `CSR_CRMD:   rval = crmd;
            `CSR_PRMD:   rval = prmd;
            `CSR_ECFG:   rval = ecfg;
            `CSR_ESTAT:  rval = estat;
            `CSR_ERA:    rval = era;
            `CSR_EENTRY: rval = eentry;
            `CSR_SAVE0:  rval = save0;
            `CSR_SAVE1:  rval = save1;
            `CSR_SAVE2:  rval = save2;
            `CSR_SAVE3:  rval = save3;
            `CSR_TCFG:   rval = tcfg;
            `CSR_TVAL:   rval = tval;
            default:     rval = '0;
        endcase
    end

endmodule

// File: csr_file.sv
`timescale 1ns/1ps

module csr_file
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_write_t wr,
    input  csr_num_t   rnum,
    input  exc_event_t exc,
    input  logic       ertn,
    output csr_data_t  rval,
    output logic       has_int,
    output csr_data_t  exc_entry,
    output csr_data_t  exc_retaddr
);

    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t ecfg;
    csr_data_t estat;
    csr_data_t era;
    csr_data_t eentry;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;
    csr_data_t tcfg;
    csr_data_t tval;
    logic      timer_pending;

    exc_csr_regs u_exc (
        .clk           (clk),
        .rst           (rst),
        .wr            (wr),
        .exc           (exc),
        .ertn          (ertn),
        .timer_pending (timer_pending),
        .crmd          (crmd),
        .prmd          (prmd),
        .ecfg          (ecfg),
        .estat         (estat),
        .era           (era),
        .eentry        (eentry),
        .has_int       (has_int),
        .exc_entry     (exc_entry),
        .exc_retaddr   (exc_retaddr)
    );

    timer_cfg u_tcfg (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .tcfg (tcfg)
    );

    csr_timer u_timer (
        .clk           (clk),
        .rst           (rst),
        .wr            (wr),
        .tcfg          (tcfg),
        .tval          (tval),
        .timer_pending (timer_pending)
    );

    csr_save_bank u_save (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .save0 (save0),
        .save1 (save1),
        .save2 (save2),
        .save3 (save3)
    );

    csr_read_select u_rsel (
        .rnum   (rnum),
        .crmd   (crmd),
        .prmd   (prmd),
        .ecfg   (ecfg),
        .estat  (estat),
        .era    (era),
        .eentry (eentry),
        .save0  (save0),
        .save1  (save1),
        .save2  (save2),
        .save3  (save3),
        .tcfg   (tcfg),
        .tval   (tval),
        .rval   (rval)
    );

endmodule

// File: csr_file_props.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_file_props
    import csr_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input csr_data_t  crmd,
    input csr_data_t  estat,
    input logic       has_int,
    input exc_event_t exc
);

    // number of assertion failures so far
    int fail_count = 0;

    // no request while globally masked
    int_needs_ie: assert property (@(posedge clk) disable iff (rst)
        has_int |-> crmd[`CSR_CRMD_IE])
        else begin
            fail_count++;
            $error("has_int high while CRMD IE is clear");
        end

    // hardware lines and IPI are not implemented
    unused_is_zero: assert property (@(posedge clk) disable iff (rst)
        estat[10:2] == 9'b0 && !estat[12])
        else begin
            fail_count++;
            $error("ESTAT interrupt bits 2 to 10 or 12 not zero");
        end

    exc_drops_plv: assert property (@(posedge clk) disable iff (rst)
        exc.valid |=> crmd[`CSR_CRMD_PLV] == 2'b00)
        else begin
            fail_count++;
            $error("CRMD PLV not zero in the cycle after an exception");
        end

endmodule

// File: csr_file_tb.sv
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_file_tb
    import csr_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 32'h037cc147;
    localparam int N_WRITES     = 200;
    localparam int N_EXC        = 10;
    localparam int MAX_N        = 8;
    // reset, reads, writes, exceptions, interrupts, one-shot, three periodic passes, margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 + 2 * N_WRITES + 12 * N_EXC + 20
                                     + 4 * (4 * MAX_N + 8) + 100;

    // writable fields per register
    localparam csr_data_t CRMD_WMASK   = 32'h0000_01ff;
    localparam csr_data_t PRMD_WMASK   = 32'h0000_0007;
    localparam csr_data_t ECFG_WMASK   = 32'h0000_1fff;
    localparam csr_data_t ESTAT_WMASK  = 32'h0000_0003;
    localparam csr_data_t EENTRY_WMASK = 32'hffff_ffc0;
    localparam csr_data_t ALL_ONES     = 32'hffff_ffff;

    logic       clk;
    logic       rst;
    csr_write_t wr;
    csr_num_t   rnum;
    exc_event_t exc;
    logic       ertn;
    csr_data_t  rval;
    logic       has_int;
    csr_data_t  exc_entry;
    csr_data_t  exc_retaddr;

    // reference register state
    csr_data_t mdl_crmd;
    csr_data_t mdl_prmd;
    csr_data_t mdl_ecfg;
    csr_data_t mdl_estat_sw;
    csr_data_t mdl_era;
    csr_data_t mdl_eentry;
    csr_data_t mdl_tcfg;
    csr_data_t mdl_tval;
    csr_data_t mdl_save [4];
    ecode_t    mdl_ecode;
    esubcode_t mdl_esub;
    logic      mdl_pend;
    csr_data_t tcfg_new;

    int        main_errors;
    int        cmp_errors;
    int        err_base;
    int        tests_run;
    int        tests_failed;
    int        i;
    int        k;
    int        n;
    int        cnt;
    csr_num_t  wnum;
    csr_data_t old_mode;
    csr_data_t pc;
    ecode_t    ec;
    esubcode_t esc;

    csr_num_t rand_nums [9] = '{`CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                                `CSR_ECFG, `CSR_PRMD, `CSR_ERA, `CSR_EENTRY, `CSR_CRMD};
    csr_num_t zero_nums [12] = '{`CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_EENTRY,
                                 `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                                 `CSR_TCFG, `CSR_TICLR, 14'h3ff};

    csr_file uut (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .rnum        (rnum),
        .exc         (exc),
        .ertn        (ertn),
        .rval        (rval),
        .has_int     (has_int),
        .exc_entry   (exc_entry),
        .exc_retaddr (exc_retaddr)
    );

    bind csr_file csr_file_props u_props (
        .clk     (clk),
        .rst     (rst),
        .crmd    (crmd),
        .estat   (estat),
        .has_int (has_int),
        .exc     (exc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic csr_data_t merge(input csr_data_t old, input csr_data_t mask,
                                        input csr_data_t val, input csr_data_t wmask);
        return (old & ~(mask & wmask)) | (val & mask & wmask);
    endfunction

    function automatic csr_data_t estat_ref();
        csr_data_t e;
        e = '0;
        e[`CSR_ESTAT_IS10]     = mdl_estat_sw[1:0];
        e[`ESTAT_TIMER_BIT]    = mdl_pend;
        e[`CSR_ESTAT_ECODE]    = mdl_ecode;
        e[`CSR_ESTAT_ESUBCODE] = mdl_esub;
        return e;
    endfunction

    function automatic csr_data_t read_ref(input csr_num_t num);
        case (num)
            `CSR_CRMD:   return mdl_crmd;
            `CSR_PRMD:   return mdl_prmd;
            `CSR_ECFG:   return mdl_ecfg;
            `CSR_ESTAT:  return estat_ref();
            `CSR_ERA:    return mdl_era;
            `CSR_EENTRY: return mdl_eentry;
            `CSR_SAVE0:  return mdl_save[0];
            `CSR_SAVE1:  return mdl_save[1];
            `CSR_SAVE2:  return mdl_save[2];
            `CSR_SAVE3:  return mdl_save[3];
            `CSR_TCFG:   return mdl_tcfg;
            `CSR_TVAL:   return mdl_tval;
            default:     return '0;
        endcase
    endfunction

    function automatic logic has_int_ref();
        return mdl_crmd[`CSR_CRMD_IE] && ((estat_ref() & mdl_ecfg) != 32'h0);
    endfunction

    // architectural update at each edge
    always @(posedge clk) begin
        if (rst) begin
            mdl_crmd     <= `CRMD_RESET;
            mdl_prmd     <= '0;
            mdl_ecfg     <= '0;
            mdl_estat_sw <= '0;
            mdl_era      <= '0;
            mdl_eentry   <= '0;
            mdl_tcfg     <= '0;
            mdl_tval     <= `TIMER_STOPPED;
            mdl_ecode    <= '0;
            mdl_esub     <= '0;
            mdl_pend     <= 1'b0;
            for (int j = 0; j < 4; j++) begin
                mdl_save[j] <= '0;
            end
        end else begin
            if (exc.valid) begin
                mdl_prmd  <= mdl_crmd & 32'h7;
                mdl_crmd  <= mdl_crmd & ~32'h7;
                mdl_ecode <= exc.ecode;
                mdl_esub  <= exc.esubcode;
                mdl_era   <= exc.pc;
            end else if (ertn) begin
                mdl_crmd <= (mdl_crmd & ~32'h7) | (mdl_prmd & 32'h7);
            end else if (wr.we) begin
                case (wr.num)
                    `CSR_CRMD:   mdl_crmd <= merge(mdl_crmd, wr.mask, wr.val, CRMD_WMASK);
                    `CSR_PRMD:   mdl_prmd <= merge(mdl_prmd, wr.mask, wr.val, PRMD_WMASK);
                    `CSR_ECFG:   mdl_ecfg <= merge(mdl_ecfg, wr.mask, wr.val, ECFG_WMASK);
                    `CSR_ESTAT:  mdl_estat_sw <= merge(mdl_estat_sw, wr.mask, wr.val, ESTAT_WMASK);
                    `CSR_ERA:    mdl_era <= merge(mdl_era, wr.mask, wr.val, ALL_ONES);
                    `CSR_EENTRY: mdl_eentry <= merge(mdl_eentry, wr.mask, wr.val, EENTRY_WMASK);
                    `CSR_SAVE0:  mdl_save[0] <= merge(mdl_save[0], wr.mask, wr.val, ALL_ONES);
                    `CSR_SAVE1:  mdl_save[1] <= merge(mdl_save[1], wr.mask, wr.val, ALL_ONES);
                    `CSR_SAVE2:  mdl_save[2] <= merge(mdl_save[2], wr.mask, wr.val, ALL_ONES);
                    `CSR_SAVE3:  mdl_save[3] <= merge(mdl_save[3], wr.mask, wr.val, ALL_ONES);
                    `CSR_TCFG:   mdl_tcfg <= merge(mdl_tcfg, wr.mask, wr.val, ALL_ONES);
                    default: ;
                endcase
            end
            // countdown, reload and pending bit
            tcfg_new = merge(mdl_tcfg, wr.mask, wr.val, ALL_ONES);
            if (wr.we && wr.num == `CSR_TCFG && tcfg_new[`CSR_TCFG_EN]) begin
                mdl_tval <= {tcfg_new[`CSR_TCFG_INITVAL], 2'b00};
            end else if (mdl_tcfg[`CSR_TCFG_EN] && mdl_tval != `TIMER_STOPPED) begin
                if (mdl_tval == 32'h0 && mdl_tcfg[`CSR_TCFG_PERIOD]) begin
                    mdl_tval <= {mdl_tcfg[`CSR_TCFG_INITVAL], 2'b00};
                end else begin
                    mdl_tval <= mdl_tval - 32'd1;
                end
            end
            if (mdl_tval == 32'h0) begin
                mdl_pend <= 1'b1;
            end else if (wr.we && wr.num == `CSR_TICLR && wr.mask[0] && wr.val[0]) begin
                mdl_pend <= 1'b0;
            end
        end
    end

    task automatic check_val(input string name, input csr_data_t got, input csr_data_t exp,
                             inout int err_count);
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_val("rval", rval, read_ref(rnum), cmp_errors);
            check_val("has_int", 32'(has_int), 32'(has_int_ref()), cmp_errors);
            check_val("exc_entry", exc_entry, mdl_eentry, cmp_errors);
            check_val("exc_retaddr", exc_retaddr, mdl_era, cmp_errors);
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic write_csr(input csr_num_t num, input csr_data_t mask, input csr_data_t val);
        wr.we   = 1'b1;
        wr.num  = num;
        wr.mask = mask;
        wr.val  = val;
        next_cycle();
        wr.we = 1'b0;
    endtask

    task automatic read_check(input string name, input csr_num_t num, input csr_data_t mask,
                              input csr_data_t exp);
        rnum = num;
        next_cycle();
        check_val(name, rval & mask, exp, main_errors);
    endtask

    // procedural checks, compare process and bound assertions together
    function automatic int error_total();
        return main_errors + cmp_errors + uut.u_props.fail_count;
    endfunction

    task automatic finish_test(input string name);
        int total;
        total = error_total();
        tests_run++;
        if (total == err_base) begin
            $display("test %-16s passed", name);
        end else begin
            tests_failed++;
            $display("test %-16s failed with %0d errors", name, total - err_base);
        end
        err_base = total;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst  = 1'b1;
        wr   = '0;
        rnum = '0;
        exc  = '0;
        ertn = 1'b0;
        main_errors  = 0;
        cmp_errors   = 0;
        err_base     = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        read_check("crmd", `CSR_CRMD, ALL_ONES, `CRMD_RESET);
        read_check("tval", `CSR_TVAL, ALL_ONES, `TIMER_STOPPED);
        for (i = 0; i < 12; i++) begin
            read_check("reset_zero", zero_nums[i], ALL_ONES, 32'h0);
        end
        check_val("has_int", 32'(has_int), 32'h0, main_errors);
        finish_test("reset_values");

        for (i = 0; i < N_WRITES; i++) begin
            k = $urandom_range(8, 0);
            wnum = rand_nums[k];
            rnum = wnum;
            write_csr(wnum, $urandom, $urandom);
            if (wnum == `CSR_EENTRY) begin
                check_val("eentry_low", rval & 32'h3f, 32'h0, main_errors);
            end
        end
        // last value written to each register
        for (i = 0; i < 9; i++) begin
            read_check("readback", rand_nums[i], ALL_ONES, read_ref(rand_nums[i]));
        end
        finish_test("masked_writes");

        for (i = 0; i < N_EXC; i++) begin
            old_mode = $urandom_range(7, 0);
            write_csr(`CSR_CRMD, 32'h7, old_mode);
            ec  = ecode_t'($urandom);
            esc = esubcode_t'($urandom);
            pc  = $urandom;
            exc.valid    = 1'b1;
            exc.ecode    = ec;
            exc.esubcode = esc;
            exc.pc       = pc;
            next_cycle();
            exc.valid = 1'b0;
            read_check("crmd_plv_ie", `CSR_CRMD, 32'h7, 32'h0);
            read_check("prmd_saved", `CSR_PRMD, 32'h7, old_mode);
            read_check("era", `CSR_ERA, ALL_ONES, pc);
            check_val("exc_retaddr", exc_retaddr, pc, main_errors);
            read_check("estat_ecode", `CSR_ESTAT, 32'h003f_0000, 32'(ec) << 16);
            read_check("estat_esubcode", `CSR_ESTAT, 32'h7fc0_0000, 32'(esc) << 22);
            ertn = 1'b1;
            next_cycle();
            ertn = 1'b0;
            read_check("crmd_restored", `CSR_CRMD, 32'h7, old_mode);
        end
        finish_test("exception_ertn");

        write_csr(`CSR_ECFG, ALL_ONES, 32'h3);
        write_csr(`CSR_ESTAT, 32'h3, 32'h1);
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        check_val("has_int", 32'(has_int), 32'h1, main_errors);
        write_csr(`CSR_CRMD, 32'h4, 32'h0);
        check_val("has_int", 32'(has_int), 32'h0, main_errors);
        write_csr(`CSR_CRMD, 32'h4, 32'h4);
        check_val("has_int", 32'(has_int), 32'h1, main_errors);
        write_csr(`CSR_ECFG, 32'h3, 32'h0);
        check_val("has_int", 32'(has_int), 32'h0, main_errors);
        write_csr(`CSR_ESTAT, 32'h3, 32'h0);
        finish_test("soft_interrupt");

        // one-shot countdown
        n = $urandom_range(MAX_N, 1);
        rnum = `CSR_TVAL;
        write_csr(`CSR_TCFG, ALL_ONES, (32'(n) << 2) | 32'h1);
        check_val("tval_load", rval, 32'(4 * n), main_errors);
        rnum = `CSR_ESTAT;
        cnt = 0;
        do begin
            next_cycle();
            cnt++;
        end while (!rval[`ESTAT_TIMER_BIT] && cnt < 4 * n + 8);
        if (!rval[`ESTAT_TIMER_BIT]) begin
            main_errors++;
            $display("timer pending bit never set after the one-shot countdown");
        end
        check_val("pending_delay", 32'(cnt), 32'(4 * n + 1), main_errors);
        read_check("tval_stopped", `CSR_TVAL, ALL_ONES, `TIMER_STOPPED);
        rnum = `CSR_ESTAT;
        write_csr(`CSR_TICLR, 32'h1, 32'h1);
        check_val("estat_is11", 32'(rval[`ESTAT_TIMER_BIT]), 32'h0, main_errors);
        write_csr(`CSR_TCFG, ALL_ONES, 32'h0);
        finish_test("timer_oneshot");

        n = $urandom_range(MAX_N, 1);
        rnum = `CSR_TVAL;
        write_csr(`CSR_TCFG, ALL_ONES, (32'(n) << 2) | 32'h3);
        for (i = 0; i < 3; i++) begin
            cnt = 0;
            do begin
                next_cycle();
                cnt++;
            end while (rval != 32'h0 && cnt < 4 * n + 4);
            if (rval != 32'h0) begin
                main_errors++;
                $display("periodic timer never reached zero on pass %0d", i);
            end
            next_cycle();
            check_val("tval_reload", rval, 32'(4 * n), main_errors);
            rnum = `CSR_ESTAT;
            next_cycle();
            check_val("estat_is11", 32'(rval[`ESTAT_TIMER_BIT]), 32'h1, main_errors);
            write_csr(`CSR_TICLR, 32'h1, 32'h1);
            check_val("estat_is11", 32'(rval[`ESTAT_TIMER_BIT]), 32'h0, main_errors);
            rnum = `CSR_TVAL;
        end
        write_csr(`CSR_TCFG, ALL_ONES, 32'h0);
        finish_test("timer_periodic");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: csr_file.f
+incdir+.
csr_pkg.sv
exc_csr_regs.sv
timer_cfg.sv
csr_timer.sv
csr_save_bank.sv
csr_read_select.sv
csr_file.sv
csr_file_props.sv
csr_file_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= csr_file_tb
FILELIST  ?= csr_file.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
